//--- hw/soc_pkg.sv
// soc package: native bus widths, address map, register offsets and interrupt bits
package soc_pkg;

  // native bus widths
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  parameter int STRB_W = DATA_W / 8;

  // address map, each register target owns one 4 KiB window
  parameter logic [ADDR_W-1:0] SRAM_BASE    = 32'h0000_0000;
  parameter logic [ADDR_W-1:0] SYSCTRL_BASE = 32'h1000_0000;
  parameter logic [ADDR_W-1:0] DMA_BASE     = 32'h1000_1000;
  parameter logic [ADDR_W-1:0] TGT_SPAN     = 32'h0000_1000;

  // identification word of the system control block
  parameter logic [DATA_W-1:0] SYSCTRL_ID_VALUE = 32'h50C0_0101;

  // system control register offsets
  parameter logic [ADDR_W-1:0] REG_IRQ_PEND = 32'h0;
  parameter logic [ADDR_W-1:0] REG_IRQ_EN   = 32'h4;
  parameter logic [ADDR_W-1:0] REG_SCRATCH  = 32'h8;
  parameter logic [ADDR_W-1:0] REG_ID       = 32'hC;

  // dma register offsets
  parameter logic [ADDR_W-1:0] REG_DMA_SRC  = 32'h0;
  parameter logic [ADDR_W-1:0] REG_DMA_DST  = 32'h4;
  parameter logic [ADDR_W-1:0] REG_DMA_LEN  = 32'h8;
  parameter logic [ADDR_W-1:0] REG_DMA_CTRL = 32'hC;

  // interrupt vector layout
  parameter int IRQ_W        = 2;
  parameter int IRQ_DMA_DONE = 0;
  parameter int IRQ_EXTN     = 1;

endpackage

//--- hw/nmi_arbiter.sv
`timescale 1ns/10ps
// native bus arbiter: round-robin between two masters, grant held until the access completes
module nmi_arbiter (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       m0_valid_i,
  input  logic [soc_pkg::ADDR_W-1:0] m0_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] m0_wdata_i,
  input  logic [soc_pkg::STRB_W-1:0] m0_wstrb_i,
  output logic [soc_pkg::DATA_W-1:0] m0_rdata_o,
  output logic                       m0_ready_o,
  input  logic                       m1_valid_i,
  input  logic [soc_pkg::ADDR_W-1:0] m1_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] m1_wdata_i,
  input  logic [soc_pkg::STRB_W-1:0] m1_wstrb_i,
  output logic [soc_pkg::DATA_W-1:0] m1_rdata_o,
  output logic                       m1_ready_o,
  output logic                       bus_valid_o,
  output logic [soc_pkg::ADDR_W-1:0] bus_addr_o,
  output logic [soc_pkg::DATA_W-1:0] bus_wdata_o,
  output logic [soc_pkg::STRB_W-1:0] bus_wstrb_o,
  input  logic [soc_pkg::DATA_W-1:0] bus_rdata_i,
  input  logic                       bus_ready_i
);

  logic locked_q;
  logic owner_q;
  logic last_q;
  logic pick;
  logic grant;

  // free bus: favour the master that did not own the last access
  always_comb begin
    if (m0_valid_i && m1_valid_i) begin
      pick = ~last_q;
    end else begin
      pick = m1_valid_i;
    end
  end

  assign grant = locked_q ? owner_q : pick;

  assign bus_valid_o = grant ? m1_valid_i : m0_valid_i;
  assign bus_addr_o  = grant ? m1_addr_i  : m0_addr_i;
  assign bus_wdata_o = grant ? m1_wdata_i : m0_wdata_i;
  assign bus_wstrb_o = grant ? m1_wstrb_i : m0_wstrb_i;

  // response goes back to the owner only
  assign m0_ready_o = ~grant & bus_ready_i;
  assign m0_rdata_o = grant ? '0 : bus_rdata_i;
  assign m1_ready_o = grant & bus_ready_i;
  assign m1_rdata_o = grant ? bus_rdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      locked_q <= 1'b0;
      owner_q  <= 1'b0;
      last_q   <= 1'b1;
    end else if (bus_ready_i) begin
      locked_q <= 1'b0;
      last_q   <= grant;
    end else if (bus_valid_o) begin
      // access in flight, keep it on this master
      locked_q <= 1'b1;
      owner_q  <= grant;
    end
  end

endmodule

//--- hw/nmi_decoder.sv
`timescale 1ns/10ps
// native bus decoder: routes the granted access to sram, sysctrl or dma and answers unmapped ones
module nmi_decoder #(
  parameter int SRAM_WORDS = 1024
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       bus_valid_i,
  input  logic [soc_pkg::ADDR_W-1:0] bus_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] bus_wdata_i,
  input  logic [soc_pkg::STRB_W-1:0] bus_wstrb_i,
  output logic [soc_pkg::DATA_W-1:0] bus_rdata_o,
  output logic                       bus_ready_o,
  output logic                       sram_valid_o,
  output logic [soc_pkg::ADDR_W-1:0] sram_addr_o,
  output logic [soc_pkg::DATA_W-1:0] sram_wdata_o,
  output logic [soc_pkg::STRB_W-1:0] sram_wstrb_o,
  input  logic [soc_pkg::DATA_W-1:0] sram_rdata_i,
  input  logic                       sram_ready_i,
  output logic                       sys_valid_o,
  output logic [soc_pkg::ADDR_W-1:0] sys_addr_o,
  output logic [soc_pkg::DATA_W-1:0] sys_wdata_o,
  output logic [soc_pkg::STRB_W-1:0] sys_wstrb_o,
  input  logic [soc_pkg::DATA_W-1:0] sys_rdata_i,
  input  logic                       sys_ready_i,
  output logic                       dma_valid_o,
  output logic [soc_pkg::ADDR_W-1:0] dma_addr_o,
  output logic [soc_pkg::DATA_W-1:0] dma_wdata_o,
  output logic [soc_pkg::STRB_W-1:0] dma_wstrb_o,
  input  logic [soc_pkg::DATA_W-1:0] dma_rdata_i,
  input  logic                       dma_ready_i
);
  import soc_pkg::*;

  localparam logic [ADDR_W-1:0] SRAM_SPAN = ADDR_W'(SRAM_WORDS * 4);

  logic [ADDR_W-1:0] sram_off;
  logic [ADDR_W-1:0] sys_off;
  logic [ADDR_W-1:0] dma_off;
  logic              hit_sram;
  logic              hit_sys;
  logic              hit_dma;
  logic              hit_none;
  logic              none_ready_q;

  // offset below span means the address sits inside the window
  assign sram_off = bus_addr_i - SRAM_BASE;
  assign sys_off  = bus_addr_i - SYSCTRL_BASE;
  assign dma_off  = bus_addr_i - DMA_BASE;
  assign hit_sram = sram_off < SRAM_SPAN;
  assign hit_sys  = sys_off < TGT_SPAN;
  assign hit_dma  = dma_off < TGT_SPAN;
  assign hit_none = ~(hit_sram | hit_sys | hit_dma);

  assign sram_valid_o = bus_valid_i & hit_sram;
  assign sram_addr_o  = sram_off;
  assign sram_wdata_o = bus_wdata_i;
  assign sram_wstrb_o = bus_wstrb_i;
  assign sys_valid_o  = bus_valid_i & hit_sys;
  assign sys_addr_o   = sys_off;
  assign sys_wdata_o  = bus_wdata_i;
  assign sys_wstrb_o  = bus_wstrb_i;
  assign dma_valid_o  = bus_valid_i & hit_dma;
  assign dma_addr_o   = dma_off;
  assign dma_wdata_o  = bus_wdata_i;
  assign dma_wstrb_o  = bus_wstrb_i;

  // unmapped responder, one cycle like the real targets
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      none_ready_q <= 1'b0;
    end else begin
      none_ready_q <= bus_valid_i & hit_none & ~none_ready_q;
    end
  end

  // address is held through the access, so it still selects the responder
  always_comb begin
    if (hit_sram) begin
      bus_ready_o = sram_ready_i;
      bus_rdata_o = sram_rdata_i;
    end else if (hit_sys) begin
      bus_ready_o = sys_ready_i;
      bus_rdata_o = sys_rdata_i;
    end else if (hit_dma) begin
      bus_ready_o = dma_ready_i;
      bus_rdata_o = dma_rdata_i;
    end else begin
      bus_ready_o = none_ready_q;
      bus_rdata_o = '0;
    end
  end

endmodule

//--- hw/sram_slave.sv
`timescale 1ns/10ps
// on-chip sram: word array with byte write strobes behind a native bus target port
module sram_slave #(
  parameter int SRAM_WORDS = 1024
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  logic [soc_pkg::ADDR_W-1:0] addr_i,
  input  logic [soc_pkg::DATA_W-1:0] wdata_i,
  input  logic [soc_pkg::STRB_W-1:0] wstrb_i,
  output logic [soc_pkg::DATA_W-1:0] rdata_o,
  output logic                       ready_o
);
  import soc_pkg::*;

  localparam int IDX_W = $clog2(SRAM_WORDS);

  logic [DATA_W-1:0] mem [SRAM_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              access;
  logic              ready_q;
  logic [DATA_W-1:0] rdata_q;

  assign idx    = addr_i[IDX_W+1:2];
  // first cycle of an access only, the ready cycle is not a new one
  assign access = valid_i & ~ready_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= mem[idx];
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rdata_o = rdata_q;
  assign ready_o = ready_q;

endmodule

//--- hw/sysctrl.sv
`timescale 1ns/10ps
// system control block: irq pending/enable registers, scratch, id word and combined irq
module sysctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  logic [soc_pkg::ADDR_W-1:0] addr_i,
  input  logic [soc_pkg::DATA_W-1:0] wdata_i,
  input  logic [soc_pkg::STRB_W-1:0] wstrb_i,
  output logic [soc_pkg::DATA_W-1:0] rdata_o,
  output logic                       ready_o,
  input  logic                       dma_done_i,
  input  logic                       extn_irq_i,
  output logic                       irq_o
);
  import soc_pkg::*;

  logic              access;
  logic              wr;
  logic              ready_q;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rd_word;
  logic [IRQ_W-1:0]  pend_q;
  logic [IRQ_W-1:0]  en_q;
  logic [IRQ_W-1:0]  irq_set;
  logic [IRQ_W-1:0]  irq_clr;
  logic [DATA_W-1:0] scratch_q;
  logic              irq_q;

  assign access = valid_i & ~ready_q;
  assign wr     = access & (|wstrb_i);

  // gather interrupt sources into the vector
  always_comb begin
    irq_set               = '0;
    irq_set[IRQ_DMA_DONE] = dma_done_i;
    irq_set[IRQ_EXTN]     = extn_irq_i;
  end

  // write one to clear
  assign irq_clr = (wr && addr_i == REG_IRQ_PEND) ? wdata_i[IRQ_W-1:0] : '0;

  always_comb begin
    rd_word = '0;
    case (addr_i)
      REG_IRQ_PEND: rd_word[IRQ_W-1:0] = pend_q;
      REG_IRQ_EN:   rd_word[IRQ_W-1:0] = en_q;
      REG_SCRATCH:  rd_word = scratch_q;
      REG_ID:       rd_word = SYSCTRL_ID_VALUE;
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q   <= 1'b0;
      pend_q    <= '0;
      en_q      <= '0;
      scratch_q <= '0;
      irq_q     <= 1'b0;
    end else begin
      ready_q <= access;
      // a new event beats a clear in the same cycle
      pend_q  <= (pend_q & ~irq_clr) | irq_set;
      irq_q   <= |(pend_q & en_q);
      if (wr && addr_i == REG_IRQ_EN) begin
        en_q <= wdata_i[IRQ_W-1:0];
      end
      if (wr && addr_i == REG_SCRATCH) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (wstrb_i[b]) begin
            scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rd_word;
    end
  end

  assign rdata_o = rdata_q;
  assign ready_o = ready_q;
  assign irq_o   = irq_q;

endmodule

//--- hw/dma_engine.sv
`timescale 1ns/10ps
// word-copy dma: register target port for setup, native bus master port for the copy
module dma_engine (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       reg_valid_i,
  input  logic [soc_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] reg_wdata_i,
  input  logic [soc_pkg::STRB_W-1:0] reg_wstrb_i,
  output logic [soc_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                       reg_ready_o,
  output logic                       mst_valid_o,
  output logic [soc_pkg::ADDR_W-1:0] mst_addr_o,
  output logic [soc_pkg::DATA_W-1:0] mst_wdata_o,
  output logic [soc_pkg::STRB_W-1:0] mst_wstrb_o,
  input  logic [soc_pkg::DATA_W-1:0] mst_rdata_i,
  input  logic                       mst_ready_i,
  output logic                       done_o
);
  import soc_pkg::*;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_READ  = 2'd1;
  localparam logic [1:0] ST_WRITE = 2'd2;
  localparam logic [1:0] ST_DONE  = 2'd3;
  localparam logic [ADDR_W-1:0] WORD_BYTES = 4;

  logic [1:0]        state_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] len_q;
  logic [DATA_W-1:0] cnt_q;
  logic [DATA_W-1:0] data_q;
  logic              reg_ready_q;
  logic [DATA_W-1:0] reg_rdata_q;
  logic [DATA_W-1:0] rd_word;
  logic              reg_acc;
  logic              reg_wr;
  logic              busy;
  logic              start;

  assign busy    = (state_q == ST_READ) | (state_q == ST_WRITE);
  assign reg_acc = reg_valid_i & ~reg_ready_q;
  assign reg_wr  = reg_acc & (|reg_wstrb_i);
  // start while busy is dropped
  assign start   = reg_wr & (reg_addr_i == REG_DMA_CTRL) & reg_wdata_i[0] & ~busy;

  always_comb begin
    rd_word = '0;
    case (reg_addr_i)
      REG_DMA_SRC:  rd_word = src_q;
      REG_DMA_DST:  rd_word = dst_q;
      REG_DMA_LEN:  rd_word = len_q;
      REG_DMA_CTRL: rd_word[0] = busy;
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_ready_q <= 1'b0;
      state_q     <= ST_IDLE;
      src_q       <= '0;
      dst_q       <= '0;
      len_q       <= '0;
      cnt_q       <= '0;
    end else begin
      reg_ready_q <= reg_acc;
      // setup registers only change while no copy runs
      if (reg_wr && !busy) begin
        case (reg_addr_i)
          REG_DMA_SRC: src_q <= reg_wdata_i;
          REG_DMA_DST: dst_q <= reg_wdata_i;
          REG_DMA_LEN: len_q <= reg_wdata_i;
          default:     ;
        endcase
      end
      case (state_q)
        ST_READ: begin
          if (mst_ready_i) begin
            state_q <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (mst_ready_i) begin
            src_q   <= src_q + WORD_BYTES;
            dst_q   <= dst_q + WORD_BYTES;
            cnt_q   <= cnt_q - 1'b1;
            state_q <= (cnt_q == 1) ? ST_DONE : ST_READ;
          end
        end
        default: begin
          // idle or done, done lasts a single cycle
          if (start) begin
            cnt_q   <= len_q;
            state_q <= (len_q == '0) ? ST_DONE : ST_READ;
          end else begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_acc) begin
      reg_rdata_q <= rd_word;
    end
    if (state_q == ST_READ && mst_ready_i) begin
      data_q <= mst_rdata_i;
    end
  end

  assign reg_rdata_o = reg_rdata_q;
  assign reg_ready_o = reg_ready_q;

  // request stays put until ready since state and addresses only move on ready
  assign mst_valid_o = busy;
  assign mst_addr_o  = (state_q == ST_WRITE) ? dst_q : src_q;
  assign mst_wdata_o = data_q;
  assign mst_wstrb_o = (state_q == ST_WRITE) ? '1 : '0;
  assign done_o      = (state_q == ST_DONE);

endmodule

//--- hw/soc_top.sv
`timescale 1ns/10ps
// soc top: host port and dma share one native bus to sram, sysctrl and the dma registers
module soc_top #(
  parameter int SRAM_WORDS = 1024
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       host_valid_i,
  input  logic [soc_pkg::ADDR_W-1:0] host_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] host_wdata_i,
  input  logic [soc_pkg::STRB_W-1:0] host_wstrb_i,
  output logic [soc_pkg::DATA_W-1:0] host_rdata_o,
  output logic                       host_ready_o,
  input  logic                       extn_irq_i,
  output logic                       irq_o
);
  import soc_pkg::*;

  // shared bus after the arbiter
  logic              bus_valid;
  logic [ADDR_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_wdata;
  logic [STRB_W-1:0] bus_wstrb;
  logic [DATA_W-1:0] bus_rdata;
  logic              bus_ready;
  // dma master side
  logic              mst_valid;
  logic [ADDR_W-1:0] mst_addr;
  logic [DATA_W-1:0] mst_wdata;
  logic [STRB_W-1:0] mst_wstrb;
  logic [DATA_W-1:0] mst_rdata;
  logic              mst_ready;
  // target ports
  logic              sram_valid;
  logic [ADDR_W-1:0] sram_addr;
  logic [DATA_W-1:0] sram_wdata;
  logic [STRB_W-1:0] sram_wstrb;
  logic [DATA_W-1:0] sram_rdata;
  logic              sram_ready;
  logic              sys_valid;
  logic [ADDR_W-1:0] sys_addr;
  logic [DATA_W-1:0] sys_wdata;
  logic [STRB_W-1:0] sys_wstrb;
  logic [DATA_W-1:0] sys_rdata;
  logic              sys_ready;
  logic              dma_valid;
  logic [ADDR_W-1:0] dma_addr;
  logic [DATA_W-1:0] dma_wdata;
  logic [STRB_W-1:0] dma_wstrb;
  logic [DATA_W-1:0] dma_rdata;
  logic              dma_ready;
  logic              dma_done;

  // host is master 0, dma is master 1
  nmi_arbiter u_nmi_arbiter (
    .clk_i(clk_i), .reset_i(reset_i),
    .m0_valid_i(host_valid_i), .m0_addr_i(host_addr_i), .m0_wdata_i(host_wdata_i),
    .m0_wstrb_i(host_wstrb_i), .m0_rdata_o(host_rdata_o), .m0_ready_o(host_ready_o),
    .m1_valid_i(mst_valid), .m1_addr_i(mst_addr), .m1_wdata_i(mst_wdata),
    .m1_wstrb_i(mst_wstrb), .m1_rdata_o(mst_rdata), .m1_ready_o(mst_ready),
    .bus_valid_o(bus_valid), .bus_addr_o(bus_addr), .bus_wdata_o(bus_wdata),
    .bus_wstrb_o(bus_wstrb), .bus_rdata_i(bus_rdata), .bus_ready_i(bus_ready)
  );

  nmi_decoder #(.SRAM_WORDS(SRAM_WORDS)) u_nmi_decoder (
    .clk_i(clk_i), .reset_i(reset_i),
    .bus_valid_i(bus_valid), .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata),
    .bus_wstrb_i(bus_wstrb), .bus_rdata_o(bus_rdata), .bus_ready_o(bus_ready),
    .sram_valid_o(sram_valid), .sram_addr_o(sram_addr), .sram_wdata_o(sram_wdata),
    .sram_wstrb_o(sram_wstrb), .sram_rdata_i(sram_rdata), .sram_ready_i(sram_ready),
    .sys_valid_o(sys_valid), .sys_addr_o(sys_addr), .sys_wdata_o(sys_wdata),
    .sys_wstrb_o(sys_wstrb), .sys_rdata_i(sys_rdata), .sys_ready_i(sys_ready),
    .dma_valid_o(dma_valid), .dma_addr_o(dma_addr), .dma_wdata_o(dma_wdata),
    .dma_wstrb_o(dma_wstrb), .dma_rdata_i(dma_rdata), .dma_ready_i(dma_ready)
  );

  sram_slave #(.SRAM_WORDS(SRAM_WORDS)) u_sram_slave (
    .clk_i(clk_i), .reset_i(reset_i),
    .valid_i(sram_valid), .addr_i(sram_addr), .wdata_i(sram_wdata),
    .wstrb_i(sram_wstrb), .rdata_o(sram_rdata), .ready_o(sram_ready)
  );

  sysctrl u_sysctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .valid_i(sys_valid), .addr_i(sys_addr), .wdata_i(sys_wdata),
    .wstrb_i(sys_wstrb), .rdata_o(sys_rdata), .ready_o(sys_ready),
    .dma_done_i(dma_done), .extn_irq_i(extn_irq_i), .irq_o(irq_o)
  );

  dma_engine u_dma_engine (
    .clk_i(clk_i), .reset_i(reset_i),
    .reg_valid_i(dma_valid), .reg_addr_i(dma_addr), .reg_wdata_i(dma_wdata),
    .reg_wstrb_i(dma_wstrb), .reg_rdata_o(dma_rdata), .reg_ready_o(dma_ready),
    .mst_valid_o(mst_valid), .mst_addr_o(mst_addr), .mst_wdata_o(mst_wdata),
    .mst_wstrb_o(mst_wstrb), .mst_rdata_i(mst_rdata), .mst_ready_i(mst_ready),
    .done_o(dma_done)
  );

endmodule

//--- tests/tb_checks.svh
// testbench helpers for soc_top: compare tasks and reference models for sram, decode and irq
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // target kinds returned by the decode model
  localparam int TGT_SRAM = 0;
  localparam int TGT_SYS  = 1;
  localparam int TGT_DMA  = 2;
  localparam int TGT_NONE = 3;

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("FAILED %s expected %b actual %b", name, exp, act);
    end
  endtask

  // byte lanes with a strobe take the new data
  function automatic logic [DATA_W-1:0] strb_merge(input logic [DATA_W-1:0] old,
                                                   input logic [DATA_W-1:0] wdata,
                                                   input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic int decode_target(input logic [ADDR_W-1:0] addr);
    if (addr < ADDR_W'(SRAM_WORDS * 4)) begin
      return TGT_SRAM;
    end
    if (addr[ADDR_W-1:12] == SYSCTRL_BASE[ADDR_W-1:12]) begin
      return TGT_SYS;
    end
    if (addr[ADDR_W-1:12] == DMA_BASE[ADDR_W-1:12]) begin
      return TGT_DMA;
    end
    return TGT_NONE;
  endfunction

  // expected read data for sram and unmapped addresses
  function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
    if (decode_target(addr) == TGT_SRAM) begin
      return sram_model[int'(addr / 4)];
    end
    return '0;
  endfunction

  // every address bit shows up in the pattern
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  function automatic logic irq_level(input logic [IRQ_W-1:0] pend, input logic [IRQ_W-1:0] en);
    return |(pend & en);
  endfunction

`endif

//--- tests/tb_soc_top.sv
`timescale 1ns/10ps
// soc_top testbench checking host accesses to sram, sysctrl and dma against reference models
module tb_soc_top;
  import soc_pkg::*;

  localparam int SRAM_WORDS  = 1024;
  localparam int CLK_PERIOD  = 4;
  localparam int POLL_MAX    = 64;
  localparam int CYCLE_BOUND = 64;
  // host accesses per test with polling loops counted at their limit
  localparam int ACC_SRAM   = 96;
  localparam int ACC_SYS    = 5;
  localparam int ACC_UNMAP  = 11;
  localparam int ACC_DMA    = 340;
  localparam int ACC_IRQ    = 300;
  localparam int WATCH_CYCLES = (ACC_SRAM + ACC_SYS + ACC_UNMAP + ACC_DMA + ACC_IRQ) * CYCLE_BOUND;

  localparam logic [ADDR_W-1:0] SRC_BASE    = 32'h0000_0100;
  localparam logic [ADDR_W-1:0] DST_BASE    = 32'h0000_0400;
  localparam logic [ADDR_W-1:0] MIRROR_BASE = 32'h0000_0800;
  localparam logic [ADDR_W-1:0] ZERO_DST    = 32'h0000_0C00;
  localparam logic [ADDR_W-1:0] UNMAPPED [4] = '{32'h0000_1000, 32'h0000_1004,
                                                 32'h1000_2000, 32'hF000_0008};

  logic              clk_i;
  logic              reset_i;
  logic              host_valid_i;
  logic [ADDR_W-1:0] host_addr_i;
  logic [DATA_W-1:0] host_wdata_i;
  logic [STRB_W-1:0] host_wstrb_i;
  logic [DATA_W-1:0] host_rdata_o;
  logic              host_ready_o;
  logic              extn_irq_i;
  logic              irq_o;

  integer            seed = 32'h33a7;
  logic [DATA_W-1:0] sram_model [SRAM_WORDS];
  logic [IRQ_W-1:0]  pend_model;
  logic [IRQ_W-1:0]  en_model;
  int                checks = 0;
  int                errors = 0;
  int                test_errs = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  // results waiting for the compare process
  string             name_q [$];
  logic [DATA_W-1:0] exp_q [$];
  logic [DATA_W-1:0] act_q [$];
  bit                kind_q [$];

  `include "tb_checks.svh"

  soc_top #(.SRAM_WORDS(SRAM_WORDS)) dut0 (
    .clk_i(clk_i), .reset_i(reset_i),
    .host_valid_i(host_valid_i), .host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i),
    .host_wstrb_i(host_wstrb_i), .host_rdata_o(host_rdata_o), .host_ready_o(host_ready_o),
    .extn_irq_i(extn_irq_i), .irq_o(irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles, the tests did not finish", WATCH_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  // drain queued results on the falling edge
  initial begin : compare_proc
    string             nm;
    logic [DATA_W-1:0] exp_v;
    logic [DATA_W-1:0] act_v;
    bit                is_bit;
    forever begin
      @(negedge clk_i);
      while (act_q.size() > 0) begin
        nm     = name_q.pop_front();
        exp_v  = exp_q.pop_front();
        act_v  = act_q.pop_front();
        is_bit = kind_q.pop_front();
        if (is_bit) begin
          check_bit(nm, exp_v[0], act_v[0]);
        end else begin
          check_word(nm, exp_v, act_v);
        end
      end
    end
  end

  task automatic expect_word(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
    kind_q.push_back(1'b0);
  endtask

  task automatic expect_bit(input string name, input logic exp, input logic act);
    name_q.push_back(name);
    exp_q.push_back(DATA_W'(exp));
    act_q.push_back(DATA_W'(act));
    kind_q.push_back(1'b1);
  endtask

  // valid and request stay put until the ready cycle
  task automatic host_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [STRB_W-1:0] wstrb, output logic [DATA_W-1:0] rdata);
    @(posedge clk_i);
    host_valid_i <= 1'b1;
    host_addr_i  <= addr;
    host_wdata_i <= wdata;
    host_wstrb_i <= wstrb;
    do begin
      @(negedge clk_i);
    end while (!host_ready_o);
    rdata = host_rdata_o;
    @(posedge clk_i);
    host_valid_i <= 1'b0;
    host_wstrb_i <= '0;
  endtask

  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] unused;
    host_access(addr, data, strb, unused);
    if (decode_target(addr) == TGT_SRAM) begin
      sram_model[int'(addr / 4)] = strb_merge(sram_model[int'(addr / 4)], data, strb);
    end
  endtask

  task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    host_access(addr, '0, '0, data);
  endtask

  task automatic fill_region(input logic [ADDR_W-1:0] base, input int words);
    for (int i = 0; i < words; i++) begin
      host_write(base + ADDR_W'(i * 4), fill_word(base + ADDR_W'(i * 4)), '1);
    end
  endtask

  task automatic sample_irq(input string name);
    @(negedge clk_i);
    expect_bit(name, irq_level(pend_model, en_model), irq_o);
  endtask

  task automatic end_test(input string name);
    while (act_q.size() != 0) @(posedge clk_i);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %s finished with %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  // host reads of the mirror region compete with the copy for the bus
  task automatic dma_copy(input string name, input logic [ADDR_W-1:0] src,
                          input logic [ADDR_W-1:0] dst, input int len);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] ctrl;
    int                polls;
    host_write(DMA_BASE + REG_DMA_SRC, src, '1);
    host_write(DMA_BASE + REG_DMA_DST, dst, '1);
    host_write(DMA_BASE + REG_DMA_LEN, DATA_W'(len), '1);
    host_write(DMA_BASE + REG_DMA_CTRL, 32'h1, '1);
    polls = 0;
    do begin
      addr = MIRROR_BASE + ADDR_W'((polls % 8) * 4);
      host_read(addr, rd);
      expect_word({name, " side read"}, model_read(addr), rd);
      host_read(DMA_BASE + REG_DMA_CTRL, ctrl);
      polls++;
    end while (ctrl[0] && polls < POLL_MAX);
    if (ctrl[0]) begin
      $display("%s: the DMA was still busy after %0d polls", name, POLL_MAX);
      errors++;
      test_errs++;
    end
    for (int i = 0; i < len; i++) begin
      sram_model[int'(dst / 4) + i] = sram_model[int'(src / 4) + i];
    end
    pend_model[IRQ_DMA_DONE] = 1'b1;
  endtask

  task automatic test_sram_strobe;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rd;
    fill_region(SRAM_BASE, 32);
    for (int i = 0; i < 32; i++) begin
      addr = ADDR_W'(($unsigned($random(seed)) % 32) * 4);
      host_write(addr, $random(seed), STRB_W'($random(seed)));
    end
    for (int i = 0; i < 32; i++) begin
      host_read(ADDR_W'(i * 4), rd);
      expect_word("sram_strobe", model_read(ADDR_W'(i * 4)), rd);
    end
    end_test("sram_strobe");
  endtask

  task automatic test_sysctrl_regs;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] data2;
    logic [DATA_W-1:0] rd;
    data = $random(seed);
    host_write(SYSCTRL_BASE + REG_SCRATCH, data, '1);
    host_read(SYSCTRL_BASE + REG_SCRATCH, rd);
    expect_word("sysctrl_regs scratch", data, rd);
    data2 = $random(seed);
    host_write(SYSCTRL_BASE + REG_SCRATCH, data2, 4'b0101);
    data = strb_merge(data, data2, 4'b0101);
    host_read(SYSCTRL_BASE + REG_SCRATCH, rd);
    expect_word("sysctrl_regs scratch strobe", data, rd);
    host_read(SYSCTRL_BASE + REG_ID, rd);
    expect_word("sysctrl_regs id", SYSCTRL_ID_VALUE, rd);
    end_test("sysctrl_regs");
  endtask

  task automatic test_unmapped;
    logic [DATA_W-1:0] rd;
    for (int k = 0; k < 4; k++) begin
      host_read(UNMAPPED[k], rd);
      expect_word("unmapped read", model_read(UNMAPPED[k]), rd);
      host_write(UNMAPPED[k], $random(seed), '1);
    end
    // these words alias the unmapped addresses in their low bits
    for (int i = 0; i < 3; i++) begin
      host_read(ADDR_W'(i * 4), rd);
      expect_word("unmapped sram intact", model_read(ADDR_W'(i * 4)), rd);
    end
    end_test("unmapped");
  endtask

  task automatic test_dma_copy;
    logic [DATA_W-1:0] rd;
    int                len;
    len = 4 + int'($unsigned($random(seed)) % 13);
    fill_region(SRC_BASE, len);
    fill_region(DST_BASE, len + 1);
    fill_region(MIRROR_BASE, 8);
    dma_copy("dma_copy", SRC_BASE, DST_BASE, len);
    // one word past the end must keep its fill
    for (int i = 0; i <= len; i++) begin
      host_read(DST_BASE + ADDR_W'(i * 4), rd);
      expect_word("dma_copy dest", model_read(DST_BASE + ADDR_W'(i * 4)), rd);
    end
    fill_region(ZERO_DST, 1);
    dma_copy("dma_copy zero", SRC_BASE, ZERO_DST, 0);
    host_read(ZERO_DST, rd);
    expect_word("dma_copy zero dest", model_read(ZERO_DST), rd);
    end_test("dma_copy");
  endtask

  task automatic test_irq;
    logic [DATA_W-1:0] rd;
    host_write(SYSCTRL_BASE + REG_IRQ_PEND, 32'h3, '1);
    pend_model = '0;
    host_write(SYSCTRL_BASE + REG_IRQ_EN, DATA_W'(1 << IRQ_DMA_DONE), '1);
    en_model = IRQ_W'(1 << IRQ_DMA_DONE);
    dma_copy("irq dma", SRC_BASE, DST_BASE, 1);
    host_read(SYSCTRL_BASE + REG_IRQ_PEND, rd);
    expect_word("irq pend dma", DATA_W'(pend_model), rd);
    sample_irq("irq dma enabled");
    host_write(SYSCTRL_BASE + REG_IRQ_PEND, DATA_W'(1 << IRQ_DMA_DONE), '1);
    pend_model[IRQ_DMA_DONE] = 1'b0;
    host_read(SYSCTRL_BASE + REG_IRQ_PEND, rd);
    expect_word("irq pend cleared", DATA_W'(pend_model), rd);
    sample_irq("irq dma cleared");
    host_write(SYSCTRL_BASE + REG_IRQ_EN, 32'h0, '1);
    en_model = '0;
    dma_copy("irq masked", SRC_BASE, DST_BASE, 1);
    host_read(SYSCTRL_BASE + REG_IRQ_PEND, rd);
    expect_word("irq pend masked", DATA_W'(pend_model), rd);
    sample_irq("irq dma masked");
    host_write(SYSCTRL_BASE + REG_IRQ_PEND, 32'h3, '1);
    pend_model = '0;
    // one cycle pulse on the external line
    @(posedge clk_i);
    extn_irq_i <= 1'b1;
    @(posedge clk_i);
    extn_irq_i <= 1'b0;
    pend_model[IRQ_EXTN] = 1'b1;
    host_read(SYSCTRL_BASE + REG_IRQ_PEND, rd);
    expect_word("irq pend extn", DATA_W'(pend_model), rd);
    sample_irq("irq extn masked");
    host_write(SYSCTRL_BASE + REG_IRQ_EN, DATA_W'(1 << IRQ_EXTN), '1);
    en_model = IRQ_W'(1 << IRQ_EXTN);
    host_read(SYSCTRL_BASE + REG_IRQ_EN, rd);
    expect_word("irq enable readback", DATA_W'(en_model), rd);
    sample_irq("irq extn enabled");
    host_write(SYSCTRL_BASE + REG_IRQ_PEND, DATA_W'(1 << IRQ_EXTN), '1);
    pend_model[IRQ_EXTN] = 1'b0;
    host_read(SYSCTRL_BASE + REG_IRQ_PEND, rd);
    expect_word("irq pend extn cleared", DATA_W'(pend_model), rd);
    sample_irq("irq extn cleared");
    end_test("irq");
  endtask

  initial begin : main_seq
    reset_i      = 1'b1;
    host_valid_i = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    host_wstrb_i = '0;
    extn_irq_i   = 1'b0;
    pend_model   = '0;
    en_model     = '0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    test_sram_strobe;
    test_sysctrl_regs;
    test_unmapped;
    test_dma_copy;
    test_irq;
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+tests
hw/soc_pkg.sv
hw/nmi_arbiter.sv
hw/nmi_decoder.sv
hw/sram_slave.sv
hw/sysctrl.sv
hw/dma_engine.sv
hw/soc_top.sv
tests/tb_soc_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the soc_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_soc_top -f flist.f

./obj_dir/Vtb_soc_top | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
